/* filelist.f */
+incdir+testbench
common/etx_pkg.sv
etx_protocol/tx_word_format.sv
etx_protocol/tx_burst_detect.sv
etx_protocol/tx_sequencer.sv
src/etx_top.sv
testbench/tb_etx_top.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_etx_top
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_etx_tests.svh */
`ifndef TB_ETX_TESTS_SVH
`define TB_ETX_TESTS_SVH

// ######################################
// expected words from the field layout
// ######################################

function automatic tx_word_t head_expect(input tx_packet_t p);
   tx_word_t w;
   w = '0;
   w[63:52] = p.dstaddr[11:0];
   w[51:50] = p.datamode;
   w[49]    = p.write;
   // access marker
   w[48]    = 1'b1;
   w[47:32] = p.dstaddr[27:12];
   w[31]    = ~p.write;
   w[23:20] = p.ctrlmode;
   w[19:16] = p.dstaddr[31:28];
   return w;
endfunction

// 16-bit halves swapped in each field
function automatic tx_word_t body_expect(input tx_packet_t p);
   tx_word_t w;
   w[63:48] = p.srcaddr[15:0];
   w[47:32] = p.srcaddr[31:16];
   w[31:16] = p.data[15:0];
   w[15:0]  = p.data[31:16];
   return w;
endfunction

// ######################################
// stimulus helpers
// ######################################

task automatic random_packet(output tx_packet_t p);
   logic [31:0] r;
   r          = $random(seed);
   p.write    = r[0];
   p.datamode = r[2:1];
   p.ctrlmode = r[6:3];
   p.dstaddr  = $random(seed);
   p.data     = $random(seed);
   p.srcaddr  = $random(seed);
endtask

task automatic present_packet(input tx_packet_t p);
   etx_access = 1'b1;
   etx_packet = p;
endtask

task automatic drop_access();
   etx_access = 1'b0;
endtask

// next edge, then frame, word and both waits
// data word only checked outside idle
task automatic step_check(input string name, input tx_frame_t frame, input tx_word_t word,
                          input logic rd, input logic wr);
   @(posedge clk);
   #1;
   check_value({name, " frame"}, 64'(frame), 64'(tx_frame_slow));
   if (frame != FRAME_IDLE)
      check_value({name, " data"}, word, tx_data_slow);
   check_value({name, " etx_rd_wait"}, 64'(rd), 64'(etx_rd_wait));
   check_value({name, " etx_wr_wait"}, 64'(wr), 64'(etx_wr_wait));
endtask

// ######################################
// directed tests
// ######################################

// idle frame, waits pass straight through
task automatic test_reset_idle();
   step_check("reset_idle", FRAME_IDLE, '0, 1'b0, 1'b0);
   tx_rd_wait = 1'b1;
   step_check("reset_idle", FRAME_IDLE, '0, 1'b1, 1'b0);
   tx_rd_wait = 1'b0;
   tx_wr_wait = 1'b1;
   step_check("reset_idle", FRAME_IDLE, '0, 1'b0, 1'b1);
   tx_wr_wait = 1'b0;
endtask

task automatic test_lone_packet();
   tx_packet_t p;
   random_packet(p);
   present_packet(p);
   // header cycle stalls the system side
   step_check("lone_packet", FRAME_HEAD, head_expect(p), 1'b1, 1'b1);
   drop_access();
   step_check("lone_packet", FRAME_BODY, body_expect(p), 1'b0, 1'b0);
   step_check("lone_packet", FRAME_IDLE, '0, 1'b0, 1'b0);
endtask

task automatic test_back_to_back();
   tx_packet_t a;
   tx_packet_t b;
   random_packet(a);
   random_packet(b);
   // a read never continues a burst
   b.write = 1'b0;
   present_packet(a);
   step_check("back_to_back", FRAME_HEAD, head_expect(a), 1'b1, 1'b1);
   present_packet(b);
   step_check("back_to_back", FRAME_BODY, body_expect(a), 1'b0, 1'b0);
   step_check("back_to_back", FRAME_HEAD, head_expect(b), 1'b1, 1'b1);
   drop_access();
   step_check("back_to_back", FRAME_BODY, body_expect(b), 1'b0, 1'b0);
   step_check("back_to_back", FRAME_IDLE, '0, 1'b0, 1'b0);
endtask

task automatic test_burst();
   tx_packet_t beat [4];
   tx_addr_t   base;
   base = $random(seed);
   // double writes, plain ctrlmode, 8-byte steps
   for (int i = 0; i < 4; i++) begin
      random_packet(beat[i]);
      beat[i].write    = 1'b1;
      beat[i].datamode = 2'b11;
      beat[i].ctrlmode = 4'b0000;
      beat[i].dstaddr  = base + 32'(8 * i);
   end
   // fourth beat skips ahead, breaks the chain
   beat[3].dstaddr = base + 32'd40;
   present_packet(beat[0]);
   step_check("burst", FRAME_HEAD, head_expect(beat[0]), 1'b1, 1'b1);
   present_packet(beat[1]);
   step_check("burst", FRAME_BODY, body_expect(beat[0]), 1'b0, 1'b0);
   step_check("burst", FRAME_BODY, body_expect(beat[1]), 1'b0, 1'b0);
   present_packet(beat[2]);
   step_check("burst", FRAME_BODY, body_expect(beat[2]), 1'b0, 1'b0);
   present_packet(beat[3]);
   step_check("burst", FRAME_HEAD, head_expect(beat[3]), 1'b1, 1'b1);
   drop_access();
   step_check("burst", FRAME_BODY, body_expect(beat[3]), 1'b0, 1'b0);
   step_check("burst", FRAME_IDLE, '0, 1'b0, 1'b0);
endtask

// disable and IO waits hold the packet off
task automatic test_blocked();
   tx_packet_t p;
   random_packet(p);
   tx_enable = 1'b0;
   present_packet(p);
   step_check("blocked", FRAME_IDLE, '0, 1'b0, 1'b0);
   tx_enable  = 1'b1;
   tx_wr_wait = 1'b1;
   step_check("blocked", FRAME_IDLE, '0, 1'b0, 1'b1);
   tx_wr_wait = 1'b0;
   tx_rd_wait = 1'b1;
   step_check("blocked", FRAME_IDLE, '0, 1'b1, 1'b0);
   tx_rd_wait = 1'b0;
   step_check("blocked", FRAME_HEAD, head_expect(p), 1'b1, 1'b1);
   drop_access();
   step_check("blocked", FRAME_BODY, body_expect(p), 1'b0, 1'b0);
   step_check("blocked", FRAME_IDLE, '0, 1'b0, 1'b0);
endtask

`endif

/* testbench/tb_etx_top.sv */
`timescale 1ns/10ps

module tb_etx_top;
   import etx_pkg::*;

   // ######################################
   // timing
   // ######################################

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 4;
   // reset, idle 3, lone 3, back to back 5, burst 7, blocked 6
   localparam int TEST_CYCLES  = RESET_CYCLES + 3 + 3 + 5 + 7 + 6;
   // margin covers the release delay and slack
   localparam int TIMEOUT_NS   = TEST_CYCLES * CLK_PERIOD + 100;

   logic       clk;
   logic       nreset;
   logic       etx_access;
   logic       tx_enable;
   logic       tx_rd_wait;
   logic       tx_wr_wait;
   tx_packet_t etx_packet;
   logic       etx_rd_wait;
   logic       etx_wr_wait;
   tx_word_t   tx_data_slow;
   tx_frame_t  tx_frame_slow;

   // seed for random packet fields
   integer     seed;

   etx_top i_dut (
      .clk           (clk),
      .nreset        (nreset),
      .etx_access    (etx_access),
      .tx_enable     (tx_enable),
      .tx_rd_wait    (tx_rd_wait),
      .tx_wr_wait    (tx_wr_wait),
      .etx_packet    (etx_packet),
      .etx_rd_wait   (etx_rd_wait),
      .etx_wr_wait   (etx_wr_wait),
      .tx_data_slow  (tx_data_slow),
      .tx_frame_slow (tx_frame_slow)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input string test_name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("** Error: %s: expected %h, actual %h", test_name, expected, actual);
         $display("Testbench failed");
         $fatal;
      end
   endtask

   `include "tb_etx_tests.svh"

   // ######################################
   // test sequence
   // ######################################

   initial begin
      clk        = 1'b0;
      nreset     = 1'b0;
      etx_access = 1'b0;
      tx_enable  = 1'b1;
      tx_rd_wait = 1'b0;
      tx_wr_wait = 1'b0;
      etx_packet = '0;
      seed       = 36503;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      nreset = 1'b1;
      test_reset_idle();
      test_lone_packet();
      test_back_to_back();
      test_burst();
      test_blocked();
      $display("Testbench passed");
      $finish;
   end

   // stuck FSM or missing edge ends the run here
   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired, the tests did not finish in time");
      $display("Testbench failed");
      $fatal;
   end

endmodule

/* src/etx_top.sv */
`timescale 1ns/10ps

module etx_top (
   input  logic                clk,
   input  logic                nreset,
   input  logic                etx_access,
   input  logic                tx_enable,
   input  logic                tx_rd_wait,
   input  logic                tx_wr_wait,
   input  etx_pkg::tx_packet_t etx_packet,
   output logic                etx_rd_wait,
   output logic                etx_wr_wait,
   output etx_pkg::tx_word_t   tx_data_slow,
   output etx_pkg::tx_frame_t  tx_frame_slow
);
   import etx_pkg::*;

   // accept strobe from the FSM
   logic     capture;
   // next packet continues the current burst
   logic     burst_ok;
   // candidate words from the formatter
   tx_word_t head_word;
   tx_word_t body_word;

   // ######################################
   // datapath
   // ######################################

   // holds the packet, builds both words
   tx_word_format i_format (
      .clk        (clk),
      .capture    (capture),
      .etx_packet (etx_packet),
      .head_word  (head_word),
      .body_word  (body_word)
   );

   // runs beside the formatter on the same strobe
   tx_burst_detect i_burst (
      .clk        (clk),
      .nreset     (nreset),
      .capture    (capture),
      .etx_packet (etx_packet),
      .burst_ok   (burst_ok)
   );

   // ######################################
   // control
   // ######################################

   tx_sequencer i_seq (
      .clk           (clk),
      .nreset        (nreset),
      .tx_enable     (tx_enable),
      .etx_access    (etx_access),
      .burst_ok      (burst_ok),
      .tx_rd_wait    (tx_rd_wait),
      .tx_wr_wait    (tx_wr_wait),
      .head_word     (head_word),
      .body_word     (body_word),
      .capture       (capture),
      .etx_rd_wait   (etx_rd_wait),
      .etx_wr_wait   (etx_wr_wait),
      .tx_data_slow  (tx_data_slow),
      .tx_frame_slow (tx_frame_slow)
   );

endmodule

/* etx_protocol/tx_sequencer.sv */
`timescale 1ns/10ps

module tx_sequencer (
   input  logic                clk,
   input  logic                nreset,
   input  logic                tx_enable,
   input  logic                etx_access,
   input  logic                burst_ok,
   input  logic                tx_rd_wait,
   input  logic                tx_wr_wait,
   input  etx_pkg::tx_word_t   head_word,
   input  etx_pkg::tx_word_t   body_word,
   output logic                capture,
   output logic                etx_rd_wait,
   output logic                etx_wr_wait,
   output etx_pkg::tx_word_t   tx_data_slow,
   output etx_pkg::tx_frame_t  tx_frame_slow
);
   import etx_pkg::*;

   tx_state_t state;
   tx_state_t state_nxt;

   // any pushback from the IO side
   logic io_wait;
   // header cycle where the system side has to hold
   logic in_start;

   // ######################################
   // acceptance
   // ######################################

   assign io_wait  = tx_wr_wait || tx_rd_wait;
   assign in_start = (state == TX_START);

   // START is the only state that cannot take a packet
   assign capture = tx_enable && etx_access && !io_wait && !in_start;

   // ######################################
   // state machine
   // ######################################

   always_ff @(posedge clk) begin
      if (!nreset) begin
         state <= TX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         TX_IDLE: begin
            // new frame always opens with a header
            state_nxt = capture ? TX_START : TX_IDLE;
         end
         TX_START: begin
            // body word follows unconditionally
            state_nxt = TX_ACK;
         end
         TX_ACK, TX_BURST: begin
            if (capture && burst_ok) begin
               // sequential double write skips the header
               state_nxt = TX_BURST;
            end else if (capture) begin
               state_nxt = TX_START;
            end else begin
               state_nxt = TX_IDLE;
            end
         end
         default: begin
            state_nxt = TX_IDLE;
         end
      endcase
   end

   // ######################################
   // word and frame select
   // ######################################

   // data word is don't care while idle
   always_comb begin
      case (state)
         TX_START: begin
            tx_data_slow  = head_word;
            tx_frame_slow = FRAME_HEAD;
         end
         TX_ACK, TX_BURST: begin
            tx_data_slow  = body_word;
            tx_frame_slow = FRAME_BODY;
         end
         default: begin
            tx_data_slow  = body_word;
            tx_frame_slow = FRAME_IDLE;
         end
      endcase
   end

   // ######################################
   // wait back to system side
   // ######################################

   // IO waits pass straight through plus a stall in the header cycle
   assign etx_wr_wait = tx_wr_wait || in_start;
   assign etx_rd_wait = tx_rd_wait || in_start;

endmodule

/* etx_protocol/tx_burst_detect.sv */
`timescale 1ns/10ps

module tx_burst_detect (
   input  logic                clk,
   input  logic                nreset,
   input  logic                capture,
   input  etx_pkg::tx_packet_t etx_packet,
   output logic                burst_ok
);
   import etx_pkg::*;

   // incoming packet qualifies as a burst beat
   logic     in_burstable;
   // held packet qualified when it was taken
   logic     burstable;
   // address a continuation has to carry
   tx_addr_t next_addr;
   // incoming address lines up with the last beat
   logic     addr_match;

   // ######################################
   // qualify incoming packet
   // ######################################

   // double write, no ctrlmode bits set
   assign in_burstable = etx_packet.write
                         && (etx_packet.datamode == DATAMODE_DOUBLE)
                         && (etx_packet.ctrlmode == CTRLMODE_PLAIN);

   // ######################################
   // records of the accepted packet
   // ######################################

   always_ff @(posedge clk) begin
      if (!nreset) begin
         burstable <= 1'b0;
      end else if (capture) begin
         burstable <= in_burstable;
      end
   end

   // step forward by one double word
   always_ff @(posedge clk) begin
      if (capture) begin
         next_addr <= etx_packet.dstaddr + BURST_STRIDE;
      end
   end

   // ######################################
   // continuation check
   // ######################################

   assign addr_match = (etx_packet.dstaddr == next_addr);

   // access strobe is left to the sequencer
   assign burst_ok = burstable && in_burstable && addr_match;

endmodule

/* etx_protocol/tx_word_format.sv */
`timescale 1ns/10ps

module tx_word_format (
   input  logic                clk,
   input  logic                capture,
   input  etx_pkg::tx_packet_t etx_packet,
   output etx_pkg::tx_word_t   head_word,
   output etx_pkg::tx_word_t   body_word
);
   import etx_pkg::*;

   // ######################################
   // held packet
   // ######################################

   // packet accepted by the sequencer
   tx_packet_t held;

   // unpacked fields of the held packet
   logic       hd_write;
   logic [1:0] hd_datamode;
   logic [3:0] hd_ctrlmode;
   tx_addr_t   hd_dstaddr;
   tx_data_t   hd_data;
   tx_addr_t   hd_srcaddr;

   // loads on capture only
   always_ff @(posedge clk) begin
      if (capture) begin
         held <= etx_packet;
      end
   end

   assign hd_write    = held.write;
   assign hd_datamode = held.datamode;
   assign hd_ctrlmode = held.ctrlmode;
   assign hd_dstaddr  = held.dstaddr;
   assign hd_data     = held.data;
   assign hd_srcaddr  = held.srcaddr;

   // ######################################
   // header word
   // ######################################

   // 63:48 low addr, mode bits and access marker
   // 47:32 middle address bits
   // 31:24 read flag plus reserved zeros
   // 23:16 ctrlmode and top nibble of address
   // 15:0  unused lane left out by frame 0111
   assign head_word = {hd_dstaddr[11:0],
                       hd_datamode,
                       hd_write,
                       1'b1,
                       hd_dstaddr[27:12],
                       ~hd_write,
                       7'b0000000,
                       hd_ctrlmode,
                       hd_dstaddr[31:28],
                       16'h0000};

   // ######################################
   // body word
   // ######################################

   // halves swapped inside each 32-bit field
   // to match the receive side byte order
   assign body_word = {hd_srcaddr[15:0],
                       hd_srcaddr[31:16],
                       hd_data[15:0],
                       hd_data[31:16]};

endmodule

/* common/etx_pkg.sv */
package etx_pkg;

   // ######################################
   // field widths with a meaning
   // ######################################

   // emesh address and data
   typedef logic [31:0] tx_addr_t;
   typedef logic [31:0] tx_data_t;

   // slow side word towards the serializer
   typedef logic [63:0] tx_word_t;

   // frame pattern with one bit per 16-bit lane
   typedef logic [3:0]  tx_frame_t;

   // 103-bit mesh packet as seen on the system side
   typedef struct packed {
      logic       write;
      logic [1:0] datamode;
      logic [3:0] ctrlmode;
      tx_addr_t   dstaddr;
      tx_data_t   data;
      tx_addr_t   srcaddr;
   } tx_packet_t;

   // transmit FSM
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_START = 2'd1,
      TX_ACK   = 2'd2,
      TX_BURST = 2'd3
   } tx_state_t;

   // ######################################
   // field values
   // ######################################

   // double word transfer
   localparam logic [1:0] DATAMODE_DOUBLE = 2'b11;
   // no special ctrl handling
   localparam logic [3:0] CTRLMODE_PLAIN  = 4'b0000;
   // address step between burst beats
   localparam tx_addr_t   BURST_STRIDE    = 32'd8;

   // frame patterns
   localparam tx_frame_t  FRAME_IDLE = 4'b0000;
   // header word leaves its low lane empty
   localparam tx_frame_t  FRAME_HEAD = 4'b0111;
   // addr/data word fills all four lanes
   localparam tx_frame_t  FRAME_BODY = 4'b1111;

endpackage
